// File: verilog/video_config.svh
// Video output stage parameters
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// palette index and CRAM address width
`define VIDEO_INDEX_BITS 8

// one CRAM word, three channels of coarse plus fine
`define VIDEO_COLOR_BITS 15

// DAC level per channel
`define VIDEO_LEVEL_BITS 2

// fine intensity, selects the dither pattern
`define VIDEO_FINE_BITS 3

`endif

// File: verilog/video_pkg.sv
// Video output shared types
`include "video_config.svh"

package video_pkg;

	// palette index, also the CRAM address
	typedef logic [`VIDEO_INDEX_BITS-1:0] clut_index_t;

	// {red coarse, red fine, grn coarse, grn fine, blu coarse, blu fine}
	typedef logic [`VIDEO_COLOR_BITS-1:0] color_t;

	typedef logic [`VIDEO_LEVEL_BITS-1:0] dac_level_t;

	typedef logic [`VIDEO_FINE_BITS-1:0] fine_t;

	typedef struct packed {
		dac_level_t red;
		dac_level_t grn;
		dac_level_t blu;
	} rgb_level_t;

	// ph0 goes out in the first half of the clock, ph1 in the second
	typedef struct packed {
		rgb_level_t ph0;
		rgb_level_t ph1;
	} dac_pair_t;

	typedef struct packed {
		clut_index_t addr;
		color_t      data;
		logic        we;
	} cram_wr_t;

	typedef struct packed {
		logic       vga_on;
		logic       tv_hires;
		logic       vga_hires;
		logic [3:0] palsel;
		logic       vga_line;
		// bit 0 for VGA, bit 1 for TV; 1 picks the low nibble
		logic [1:0] nib_sel;
	} video_mode_t;

endpackage

// File: verilog/video_cram.sv
// Color RAM
`timescale 1ns/100ps
`include "video_config.svh"

module video_cram (
	input  logic                   clk,
	input  video_pkg::cram_wr_t    wr,
	input  video_pkg::clut_index_t rd_addr,
	output video_pkg::color_t      rd_data
);

	localparam int DEPTH = 1 << `VIDEO_INDEX_BITS;

	// palette storage, written by the CPU
	video_pkg::color_t mem [DEPTH];

	// CPU side write port
	always_ff @(posedge clk)
	begin
		if (wr.we)
		begin
			mem[wr.addr] <= wr.data;
		end
	end

	// video side read, one clock latency
	// a write and a read of the same address on one edge return the old word
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: verilog/video_src_mux.sv
// Video pixel source selection
`timescale 1ns/100ps
`include "video_config.svh"

module video_src_mux (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   c3,
	input  video_pkg::video_mode_t mode,
	input  video_pkg::clut_index_t tv_pix,
	input  video_pkg::clut_index_t vga_pix,
	input  logic                   tv_blank,
	input  logic                   vga_blank,
	output video_pkg::clut_index_t pix_addr,
	output logic                   blank_q
);

	localparam int IDX_BITS = `VIDEO_INDEX_BITS;
	localparam int NIB_BITS = IDX_BITS / 2;

	// TV pixel held between c3 strobes
	video_pkg::clut_index_t tv_pix_q;

	video_pkg::clut_index_t src_pix;
	logic                   hires;
	logic                   nib_lo;
	logic                   blank;
	logic [NIB_BITS-1:0]    nibble;

	// TV capture
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tv_pix_q <= '0;
		end
		else if (c3)
		begin
			tv_pix_q <= tv_pix;
		end
	end

	// per-source selection
	always_comb
	begin
		if (mode.vga_on)
		begin
			src_pix = vga_pix;
			hires   = mode.vga_hires;
			nib_lo  = mode.nib_sel[0];
			blank   = vga_blank;
		end
		else
		begin
			src_pix = tv_pix_q;
			hires   = mode.tv_hires;
			nib_lo  = mode.nib_sel[1];
			blank   = tv_blank;
		end
	end

	// hires pixel carries two 4-bit indices, pick one
	assign nibble = nib_lo ? src_pix[NIB_BITS-1:0] : src_pix[IDX_BITS-1:NIB_BITS];

	// palette select forms the upper half of the address in hires
	always_comb
	begin
		if (hires)
		begin
			pix_addr = {mode.palsel, nibble};
		end
		else
		begin
			pix_addr = src_pix;
		end
	end

	// blank follows the CRAM read by one clock
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			blank_q <= 1'b0;
		end
		else
		begin
			blank_q <= blank;
		end
	end

endmodule

// File: verilog/video_dither.sv
// Color dither and DAC levels
`timescale 1ns/100ps
`include "video_config.svh"

module video_dither (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 vga_on,
	input  logic                 vga_line,
	input  logic                 blank,
	input  video_pkg::color_t    color,
	output video_pkg::dac_pair_t dac
);

	localparam int LEVEL_BITS = `VIDEO_LEVEL_BITS;
	localparam video_pkg::dac_level_t LEVEL_MAX = {LEVEL_BITS{1'b1}};

	// 8 bits per pattern, 4 phases of 2 half-clocks
	function automatic logic [7:0] pattern(input video_pkg::fine_t fine);
		logic [7:0] p;
		case (fine)
			3'd0: p = 8'h00;
			3'd1: p = 8'h01;
			3'd2: p = 8'h41;
			3'd3: p = 8'h45;
			3'd4: p = 8'hA5;
			3'd5: p = 8'hA7;
			3'd6: p = 8'hD7;
			default: p = 8'hDF;
		endcase
		return p;
	endfunction

	// bump the coarse level by one where the pattern says so, top level stays
	function automatic video_pkg::dac_level_t dither_level(
		input video_pkg::dac_level_t coarse,
		input video_pkg::fine_t      fine,
		input logic [2:0]            bit_idx
	);
		logic [7:0] p;
		p = pattern(fine);
		if (p[bit_idx] && (coarse != LEVEL_MAX))
		begin
			return video_pkg::dac_level_t'(coarse + 1'b1);
		end
		return coarse;
	endfunction

	video_pkg::color_t     pix;
	video_pkg::dac_level_t red_c;
	video_pkg::dac_level_t grn_c;
	video_pkg::dac_level_t blu_c;
	video_pkg::fine_t      red_f;
	video_pkg::fine_t      grn_f;
	video_pkg::fine_t      blu_f;

	logic [1:0] ph;
	logic [1:0] phase;

	video_pkg::rgb_level_t lvl0;
	video_pkg::rgb_level_t lvl1;

	// blanking forces black
	assign pix = blank ? '0 : color;

	assign {red_c, red_f, grn_c, grn_f, blu_c, blu_f} = pix;

	// free-running dither phase
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ph <= 2'd0;
		end
		else
		begin
			ph <= ph + 2'd1;
		end
	end

	// VGA alternates the pattern on odd lines instead of every other pair of clocks
	assign phase = {vga_on ? vga_line : ph[1], ph[0]};

	always_comb
	begin
		lvl0.red = dither_level(red_c, red_f, {phase, 1'b0});
		lvl0.grn = dither_level(grn_c, grn_f, {phase, 1'b0});
		lvl0.blu = dither_level(blu_c, blu_f, {phase, 1'b0});
		lvl1.red = dither_level(red_c, red_f, {phase, 1'b1});
		lvl1.grn = dither_level(grn_c, grn_f, {phase, 1'b1});
		lvl1.blu = dither_level(blu_c, blu_f, {phase, 1'b1});
	end

	// both halves registered together, serialised by the output cell
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dac <= '0;
		end
		else
		begin
			dac.ph0 <= lvl0;
			dac.ph1 <= lvl1;
		end
	end

endmodule

// File: verilog/video_out.sv
// Video color output stage
`timescale 1ns/100ps

module video_out (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   c3,
	input  video_pkg::video_mode_t mode,
	input  video_pkg::clut_index_t tv_pix,
	input  video_pkg::clut_index_t vga_pix,
	input  logic                   tv_blank,
	input  logic                   vga_blank,
	input  video_pkg::cram_wr_t    cram_wr,
	output video_pkg::dac_pair_t   dac
);

	// palette address, combinational from the mux
	video_pkg::clut_index_t pix_addr;

	// blank aligned with CRAM read data
	logic blank_q;

	// looked-up color
	video_pkg::color_t color;

	// source select, TV capture, hires nibble
	video_src_mux u_src_mux (
		.clk       (clk),
		.arst_n    (arst_n),
		.c3        (c3),
		.mode      (mode),
		.tv_pix    (tv_pix),
		.vga_pix   (vga_pix),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.pix_addr  (pix_addr),
		.blank_q   (blank_q)
	);

	// palette
	video_cram u_cram (
		.clk     (clk),
		.wr      (cram_wr),
		.rd_addr (pix_addr),
		.rd_data (color)
	);

	// vga_on and vga_line go in as levels
	video_dither u_dither (
		.clk      (clk),
		.arst_n   (arst_n),
		.vga_on   (mode.vga_on),
		.vga_line (mode.vga_line),
		.blank    (blank_q),
		.color    (color),
		.dac      (dac)
	);

endmodule

// File: tests/tb_video_out.sv
// Video output stage testbench
`timescale 1ns/100ps
`include "video_config.svh"

module tb_video_out;

	localparam int CLK_NS = 8;
	localparam int DEPTH = 1 << `VIDEO_INDEX_BITS;
	localparam int WATCHDOG_NS = 200000;

	// one dither pattern per fine intensity
	localparam logic [7:0] DITHER_TABLE [8] = '{
		8'h00, 8'h01, 8'h41, 8'h45, 8'hA5, 8'hA7, 8'hD7, 8'hDF
	};

	logic                   clk;
	logic                   arst_n;
	logic                   c3;
	video_pkg::video_mode_t mode;
	video_pkg::clut_index_t tv_pix;
	video_pkg::clut_index_t vga_pix;
	logic                   tv_blank;
	logic                   vga_blank;
	video_pkg::cram_wr_t    cram_wr;
	video_pkg::dac_pair_t   dac;

	video_pkg::color_t shadow [DEPTH];
	logic [31:0]       lfsr = 32'h5b53;
	int                edge_cnt = 0;
	int                clk_edges;
	int                checks = 0;
	int                errors = 0;

	video_out u_video_out (
		.clk       (clk),
		.arst_n    (arst_n),
		.c3        (c3),
		.mode      (mode),
		.tv_pix    (tv_pix),
		.vga_pix   (vga_pix),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.cram_wr   (cram_wr),
		.dac       (dac)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// edges since reset release track the DUT dither counter
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			edge_cnt <= 0;
		else
			edge_cnt <= edge_cnt + 1;
	end

	// every rising edge including those in reset
	always @(posedge clk)
	begin
		clk_edges <= clk_edges + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("=== FAIL ===");
		$finish;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("simulation did not finish within the time limit");
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// dither counter value the last registered dac was built from
	function automatic logic [1:0] ph_used();
		return 2'(edge_cnt - 1);
	endfunction

	function automatic video_pkg::dac_level_t expect_level(
		input logic [1:0] coarse,
		input logic [2:0] fine,
		input logic [2:0] idx
	);
		logic [7:0] pat;
		pat = DITHER_TABLE[fine];
		if (pat[idx] && coarse < 2'd3)
			return coarse + 2'd1;
		return coarse;
	endfunction

	function automatic video_pkg::dac_pair_t expect_dac(
		input video_pkg::color_t      c,
		input logic                   blank,
		input video_pkg::video_mode_t m,
		input logic [1:0]             ph
	);
		video_pkg::color_t    px;
		logic [1:0]           phase;
		video_pkg::dac_pair_t r;
		px = blank ? 15'd0 : c;
		phase[1] = m.vga_on ? m.vga_line : ph[1];
		phase[0] = ph[0];
		r.ph0.red = expect_level(px[14:13], px[12:10], {phase, 1'b0});
		r.ph0.grn = expect_level(px[9:8], px[7:5], {phase, 1'b0});
		r.ph0.blu = expect_level(px[4:3], px[2:0], {phase, 1'b0});
		r.ph1.red = expect_level(px[14:13], px[12:10], {phase, 1'b1});
		r.ph1.grn = expect_level(px[9:8], px[7:5], {phase, 1'b1});
		r.ph1.blu = expect_level(px[4:3], px[2:0], {phase, 1'b1});
		return r;
	endfunction

	task automatic check_pair(input string name, input video_pkg::dac_pair_t exp,
		input video_pkg::dac_pair_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_level(input string name, input video_pkg::rgb_level_t exp,
		input video_pkg::rgb_level_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// returns 1 ns after the n-th rising edge
	task automatic wait_edges(input int n);
		int target;
		int waited;
		target = clk_edges + n;
		waited = 0;
		while (clk_edges < target)
		begin
			#1;
			waited++;
			if (waited > (n + 1) * CLK_NS)
				abort_run("clock edges arrived later than expected");
		end
	endtask

	task automatic cram_write(input video_pkg::clut_index_t addr, input video_pkg::color_t data);
		cram_wr.addr = addr;
		cram_wr.data = data;
		cram_wr.we = 1'b1;
		wait_edges(1);
		cram_wr.we = 1'b0;
		shadow[addr] = data;
	endtask

	task automatic fill_cram();
		for (int a = 0; a < DEPTH; a++)
			cram_write(video_pkg::clut_index_t'(a), video_pkg::color_t'(take_bits(15)));
	endtask

	task automatic reset_values();
		// entry 0 is what the mux addresses while in reset
		cram_write(8'h00, 15'h0000);
		check_pair("reset", '0, dac);
		wait_edges(2);
		check_pair("reset", '0, dac);
		arst_n = 1'b1;
		wait_edges(1);
		check_pair("reset release", '0, dac);
	endtask

	task automatic vga_lookup();
		video_pkg::clut_index_t addrs[$];
		video_pkg::clut_index_t a;
		for (int i = 0; i < 12; i++)
		begin
			a = video_pkg::clut_index_t'(take_bits(8));
			cram_write(a, video_pkg::color_t'(take_bits(15)));
			addrs.push_back(a);
		end
		// saturation at coarse 3 and fine 0 passing coarse through
		cram_write(8'hA3, {2'd3, 3'd7, 2'd3, 3'd7, 2'd3, 3'd7});
		cram_write(8'h5C, {2'd2, 3'd0, 2'd1, 3'd0, 2'd3, 3'd0});
		cram_write(8'h07, {2'd3, 3'd7, 2'd0, 3'd0, 2'd1, 3'd7});
		addrs.push_back(8'hA3);
		addrs.push_back(8'h5C);
		addrs.push_back(8'h07);
		mode = '0;
		mode.vga_on = 1'b1;
		foreach (addrs[i])
		begin
			vga_pix = addrs[i];
			wait_edges(2);
			check_pair("vga lookup", expect_dac(shadow[addrs[i]], 1'b0, mode, ph_used()), dac);
		end
	endtask

	task automatic dither_phases();
		video_pkg::dac_pair_t   exp;
		video_pkg::clut_index_t idx [2];
		idx[0] = 8'h31;
		idx[1] = 8'h32;
		cram_write(idx[0], {2'd1, 3'd1, 2'd0, 3'd2, 2'd1, 3'd3});
		cram_write(idx[1], {2'd0, 3'd4, 2'd1, 3'd5, 2'd0, 3'd6});
		mode = '0;
		mode.vga_on = 1'b1;
		for (int k = 0; k < 2; k++)
		begin
			vga_pix = idx[k];
			wait_edges(2);
			// line flag changes every other clock so all four phases show up
			for (int i = 0; i < 8; i++)
			begin
				mode.vga_line = i[1];
				wait_edges(1);
				exp = expect_dac(shadow[idx[k]], 1'b0, mode, ph_used());
				check_level("dither first half", exp.ph0, dac.ph0);
				check_level("dither second half", exp.ph1, dac.ph1);
			end
		end
	endtask

	task automatic hires_addressing();
		video_pkg::clut_index_t pix;
		video_pkg::clut_index_t addr;
		video_pkg::dac_pair_t   exp;
		for (int src = 0; src < 2; src++)
		begin
			mode = '0;
			mode.vga_on = (src == 0);
			mode.vga_hires = (src == 0);
			mode.tv_hires = (src == 1);
			for (int ps = 0; ps < 16; ps++)
			begin
				for (int nb = 0; nb < 2; nb++)
				begin
					pix = video_pkg::clut_index_t'(take_bits(8));
					mode.palsel = 4'(ps);
					// the unused source bit gets the opposite value
					mode.nib_sel[src] = nb[0];
					mode.nib_sel[1 - src] = ~nb[0];
					addr = {4'(ps), nb[0] ? pix[3:0] : pix[7:4]};
					if (src == 0)
					begin
						vga_pix = pix;
						tv_pix = ~pix;
						wait_edges(2);
						exp = expect_dac(shadow[addr], 1'b0, mode, ph_used());
						check_pair("hires vga", exp, dac);
					end
					else
					begin
						tv_pix = pix;
						vga_pix = ~pix;
						c3 = 1'b1;
						wait_edges(1);
						c3 = 1'b0;
						wait_edges(2);
						exp = expect_dac(shadow[addr], 1'b0, mode, ph_used());
						check_pair("hires tv", exp, dac);
					end
				end
			end
		end
	endtask

	task automatic tv_capture_and_blank();
		video_pkg::clut_index_t a;
		video_pkg::clut_index_t b;
		a = video_pkg::clut_index_t'(take_bits(8));
		b = a ^ 8'h5A;
		cram_write(b, ~shadow[a]);
		mode = '0;
		tv_pix = a;
		c3 = 1'b1;
		wait_edges(1);
		c3 = 1'b0;
		wait_edges(2);
		check_pair("tv capture first", expect_dac(shadow[a], 1'b0, mode, ph_used()), dac);
		// old index stays without a strobe
		tv_pix = b;
		wait_edges(3);
		check_pair("tv hold", expect_dac(shadow[a], 1'b0, mode, ph_used()), dac);
		c3 = 1'b1;
		wait_edges(1);
		c3 = 1'b0;
		wait_edges(2);
		check_pair("tv capture second", expect_dac(shadow[b], 1'b0, mode, ph_used()), dac);
		tv_blank = 1'b1;
		wait_edges(2);
		check_pair("tv blank", expect_dac(shadow[b], 1'b1, mode, ph_used()), dac);
		tv_blank = 1'b0;
		mode.vga_on = 1'b1;
		vga_pix = a;
		vga_blank = 1'b1;
		wait_edges(2);
		check_pair("vga blank", expect_dac(shadow[a], 1'b1, mode, ph_used()), dac);
		vga_blank = 1'b0;
	endtask

	initial
	begin
		arst_n = 1'b0;
		c3 = 1'b0;
		mode = '0;
		tv_pix = '0;
		vga_pix = '0;
		tv_blank = 1'b0;
		vga_blank = 1'b0;
		cram_wr = '0;
		reset_values();
		fill_cram();
		vga_lookup();
		dither_phases();
		hires_addressing();
		tv_capture_and_blank();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: video_out.f
+incdir+verilog
verilog/video_pkg.sv
verilog/video_cram.sv
verilog/video_src_mux.sv
verilog/video_dither.sv
verilog/video_out.sv
tests/tb_video_out.sv

// File: Makefile
# Verilator simulation of the video output stage

VERILATOR ?= verilator
TOP       ?= tb_video_out
FILELIST  ?= video_out.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: sim clean

# build, run, then scan the log for the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
